// File: keypadBuzzer.f
src/keypadPkg.sv
src/tonePkg.sv
src/keypadScanner.sv
src/noteFifo.sv
src/tonePlayer.sv
src/keypadBuzzer.sv
bench/keypadBuzzerTb.sv

// File: bench/keypadBuzzerTb.sv
`timescale 1ns/1ps
`default_nettype none

module keypadBuzzerTb
    import keypadPkg::*;
    import tonePkg::*;
();

    localparam int ScanPeriod    = 4;
    localparam int FifoDepth     = 4;
    localparam int NoteHalves    = 4;
    localparam int SweepCycles   = KeyLines * ScanPeriod;
    localparam int PulsesPerNote = NoteHalves / 2;
    localparam int NoteWorst     = NoteHalves * (BaseHalf + 15 * StepHalf) + 2;
    // Presses over all tests, each at most 16 sweeps long
    localparam int Presses       = 63;
    localparam int Budget        = Presses * (16 * SweepCycles + NoteWorst) + 4000;

    logic        clk;
    logic        RSTn;
    lineVec      col;
    lineVec      row;
    logic        PWM;
    logic [15:0] pressed;
    int          curCode;
    logic        pressReported;
    logic [31:0] rngState;
    int          errCnt;
    int          testsRun;
    int          testsFailed;
    int          dropCnt;
    // Reference queue and player
    int          modelQ[$];
    int          expNotes[$];
    logic        modelBusy;
    int          remain;
    // Measured high pulse widths
    int          measured[$];
    int          width;

    keypadBuzzer #(
        .ScanPeriod (ScanPeriod),
        .FifoDepth  (FifoDepth),
        .NoteHalves (NoteHalves)
    ) DUT (
        .clk  (clk),
        .RSTn (RSTn),
        .col  (col),
        .row  (row),
        .PWM  (PWM)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Keypad matrix, a column reads high for a pressed key in the driven row
    always_comb begin
        col = '0;
        for (int r = 0; r < KeyLines; r++) begin
            for (int c = 0; c < KeyLines; c++) begin
                if (row[r] && pressed[r * KeyLines + c]) begin
                    col[c] = 1'b1;
                end
            end
        end
    end

    function automatic int refHalf(input int code);
        return BaseHalf + code * StepHalf;
    endfunction

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int randCode();
        rngState = lcgNext(rngState);
        return int'(rngState[23:20]);
    endfunction

    function automatic logic quiet();
        return !modelBusy && modelQ.size() == 0 && expNotes.size() == 0
            && measured.size() == 0 && width == 0;
    endfunction

    // ----------------------------------------
    // Reference model and pulse monitor
    // ----------------------------------------

    // Scanner strobe times the pushes, codes come from the bench
    always @(negedge clk) begin : refModel
        logic fullNow;
        int   code;
        if (RSTn) begin
            fullNow = (modelQ.size() == FifoDepth);
            if (modelBusy) begin
                remain--;
                modelBusy = (remain > 0);
            end else if (modelQ.size() > 0) begin
                code = modelQ.pop_front();
                expNotes.push_back(code);
                remain    = NoteHalves * refHalf(code);
                modelBusy = 1'b1;
            end
            if (DUT.keyValid) begin
                assert (!pressReported) else begin
                    $display("Scanner reported a single press twice at %0t", $time);
                    errCnt++;
                end
                pressReported = 1'b1;
                if (fullNow) begin
                    dropCnt++;
                end else begin
                    modelQ.push_back(curCode);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!RSTn) begin
            width = 0;
        end else if (PWM) begin
            width++;
        end else if (width > 0) begin
            measured.push_back(width);
            width = 0;
        end
    end

    initial begin : compareNotes
        int code;
        int expHalf;
        int w;
        forever begin
            @(posedge clk);
            if (measured.size() >= PulsesPerNote) begin
                code    = -1;
                expHalf = 0;
                assert (expNotes.size() > 0) else begin
                    $display("A note played at %0t that no press accounts for", $time);
                    errCnt++;
                end
                if (expNotes.size() > 0) begin
                    code    = expNotes.pop_front();
                    expHalf = refHalf(code);
                end
                for (int i = 0; i < PulsesPerNote; i++) begin
                    w = measured.pop_front();
                    assert (w == expHalf) else begin
                        $display("Error at %0t: code %0d pulse %0d is %0d cycles, expected %0d",
                                 $time, code, i, w, expHalf);
                        errCnt++;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------

    task automatic pressKey(input logic [15:0] keys, input int holdSweeps);
        int lowCode;
        lowCode = 0;
        for (int i = 15; i >= 0; i--) begin
            if (keys[i]) begin
                lowCode = i;
            end
        end
        @(posedge clk);
        #2;
        pressed       = keys;
        curCode       = lowCode;
        pressReported = 1'b0;
        repeat (holdSweeps * SweepCycles) @(posedge clk);
        #2 pressed = '0;
        repeat (4 * SweepCycles) @(posedge clk);
        assert (pressReported) else begin
            $display("Press of code %0d was never reported by the scanner", lowCode);
            errCnt++;
        end
    endtask

    // Wait for all expected notes, then look for stray pulses
    task automatic drain();
        while (!quiet()) @(posedge clk);
        repeat (2 * SweepCycles) @(posedge clk);
        assert (quiet() && !PWM) else begin
            $display("PWM kept toggling after the last expected note at %0t", $time);
            errCnt++;
        end
    endtask

    task automatic finishTest(input string name, input int errStart);
        testsRun++;
        if (errCnt == errStart) begin
            $display("Test %s: pass", name);
        end else begin
            testsFailed++;
            $display("Test %s: FAIL with %0d errors", name, errCnt - errStart);
        end
    endtask

    initial begin : mainSeq
        int errStart;
        int a;
        int b;
        RSTn          = 1'b0;
        pressed       = '0;
        curCode       = 0;
        pressReported = 1'b0;
        rngState      = 32'h55e4_91a7;
        errCnt        = 0;
        testsRun      = 0;
        testsFailed   = 0;
        dropCnt       = 0;
        modelBusy     = 1'b0;
        remain        = 0;
        width         = 0;
        repeat (3) @(posedge clk);
        #2 RSTn = 1'b1;

        errStart = errCnt;
        for (int n = 0; n < 2 * SweepCycles; n++) begin
            @(negedge clk);
            assert (row == lineVec'(1 << ((n / ScanPeriod) % KeyLines)) && !PWM) else begin
                $display("Error at %0t: row %b PWM %b in cycle %0d", $time, row, PWM, n);
                errCnt++;
            end
        end
        finishTest("row scan", errStart);

        errStart = errCnt;
        a = randCode();
        pressKey(16'h0001 << a, 4);
        drain();
        finishTest("single press", errStart);

        // Long hold, then two keys together
        errStart = errCnt;
        a = randCode();
        pressKey(16'h0001 << a, 12);
        a = randCode();
        b = (a + 1 + randCode() % 15) % 16;
        pressKey((16'h0001 << a) | (16'h0001 << b), 4);
        drain();
        finishTest("hold and chord", errStart);

        errStart = errCnt;
        repeat (4) pressKey(16'h0001 << randCode(), 4);
        drain();
        finishTest("press sequence", errStart);

        // Long notes outpace the presses until the queue overflows
        errStart = errCnt;
        dropCnt  = 0;
        repeat (56) pressKey(16'h0001 << (14 + randCode() % 2), 4);
        drain();
        assert (dropCnt > 0) else begin
            $display("Overflow test never filled the queue");
            errCnt++;
        end
        finishTest("overflow", errStart);

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCnt);
        if (errCnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (Budget) @(posedge clk);
        $display("Run timed out after %0d clock cycles with notes still pending", Budget);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/keypadBuzzer.sv
`timescale 1ns/1ps
`default_nettype none

module keypadBuzzer
    import keypadPkg::*;
#(
    parameter int ScanPeriod = 50000,
    parameter int FifoDepth  = 8,
    parameter int NoteHalves = 400
) (
    input  wire logic   clk,
    input  wire logic   RSTn,
    input  wire lineVec col,
    output lineVec      row,
    output logic        PWM
);

    // ----------------------------------------
    // Scanner to queue
    // ----------------------------------------

    logic   keyValid;
    keyCode keyCodeOut;

    keypadScanner #(
        .ScanPeriod (ScanPeriod)
    ) scanner (
        .clk        (clk),
        .RSTn       (RSTn),
        .col        (col),
        .row        (row),
        .keyValid   (keyValid),
        .keyCodeOut (keyCodeOut)
    );

    // ----------------------------------------
    // Queue to player
    // ----------------------------------------

    keyCode headCode;
    logic   empty;
    logic   pop;

    noteFifo #(
        .FifoDepth (FifoDepth)
    ) queue (
        .clk      (clk),
        .RSTn     (RSTn),
        .push     (keyValid),
        .pushCode (keyCodeOut),
        .pop      (pop),
        .headCode (headCode),
        .empty    (empty)
    );

    tonePlayer #(
        .NoteHalves (NoteHalves)
    ) player (
        .clk      (clk),
        .RSTn     (RSTn),
        .empty    (empty),
        .headCode (headCode),
        .pop      (pop),
        .PWM      (PWM)
    );

endmodule

`default_nettype wire

// File: src/tonePlayer.sv
`timescale 1ns/1ps
`default_nettype none

module tonePlayer
    import keypadPkg::*;
    import tonePkg::*;
#(
    parameter int NoteHalves = 4
) (
    input  wire logic   clk,
    input  wire logic   RSTn,
    input  wire logic   empty,
    input  wire keyCode headCode,
    output logic        pop,
    output logic        PWM
);

    localparam int HalfW = (NoteHalves > 1) ? $clog2(NoteHalves) : 1;

    playState         state;
    keyCode           noteCode;
    halfPeriod        curHalf;
    halfPeriod        halfCnt;
    logic [HalfW-1:0] halfIdx;
    logic             halfEnd;
    logic             noteEnd;

    // Take the next note as soon as the player is free
    assign pop     = (state == playIdle) && !empty;

    assign curHalf = pitchHalf(noteCode);
    assign halfEnd = (state == playTone) && (halfCnt == curHalf - halfPeriod'(1));
    assign noteEnd = halfEnd && (halfIdx == HalfW'(NoteHalves - 1));

    // ----------------------------------------
    // Note sequencing
    // ----------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state   <= playIdle;
            halfCnt <= '0;
            halfIdx <= '0;
            PWM     <= 1'b0;
        end else begin
            case (state)
                playIdle: begin
                    if (pop) begin
                        // Every note opens with a high half
                        state   <= playTone;
                        halfCnt <= '0;
                        halfIdx <= '0;
                        PWM     <= 1'b1;
                    end
                end
                playTone: begin
                    if (noteEnd) begin
                        // Even count of halves, so PWM is already low here
                        state <= playIdle;
                        PWM   <= 1'b0;
                    end else if (halfEnd) begin
                        halfCnt <= '0;
                        halfIdx <= halfIdx + 1'b1;
                        PWM     <= ~PWM;
                    end else begin
                        halfCnt <= halfCnt + 1'b1;
                    end
                end
                default: begin
                    state <= playIdle;
                    PWM   <= 1'b0;
                end
            endcase
        end
    end

    // Code of the note being played
    always_ff @(posedge clk) begin
        if (pop) begin
            noteCode <= headCode;
        end
    end

endmodule

`default_nettype wire

// File: src/noteFifo.sv
`timescale 1ns/1ps
`default_nettype none

module noteFifo
    import keypadPkg::*;
#(
    parameter int FifoDepth = 8
) (
    input  wire logic   clk,
    input  wire logic   RSTn,
    input  wire logic   push,
    input  wire keyCode pushCode,
    input  wire logic   pop,
    output keyCode      headCode,
    output logic        empty
);

    localparam int AddrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CntW  = AddrW + 1;

    keyCode           mem [FifoDepth];
    logic [AddrW-1:0] wrPtr;
    logic [AddrW-1:0] rdPtr;
    logic [CntW-1:0]  count;
    logic             full;
    logic             doPush;
    logic             doPop;

    assign full     = (count == CntW'(FifoDepth));
    assign empty    = (count == '0);
    // Extra codes are simply lost, the scanner never waits
    assign doPush   = push && !full;
    assign doPop    = pop && !empty;
    assign headCode = mem[rdPtr];

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushCode;
        end
    end

endmodule

`default_nettype wire

// File: src/keypadScanner.sv
`timescale 1ns/1ps
`default_nettype none

module keypadScanner
    import keypadPkg::*;
#(
    parameter int ScanPeriod = 50000
) (
    input  wire logic   clk,
    input  wire logic   RSTn,
    input  wire lineVec col,
    output lineVec      row,
    output logic        keyValid,
    output keyCode      keyCodeOut
);

    localparam int CntW = (ScanPeriod > 1) ? $clog2(ScanPeriod) : 1;
    localparam int IdxW = $clog2(KeyLines);

    // Lowest set column wins
    function automatic logic [IdxW-1:0] lowestCol(input lineVec bits);
        logic [IdxW-1:0] idx;
        idx = '0;
        for (int i = KeyLines - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = IdxW'(i);
            end
        end
        return idx;
    endfunction

    scanState        state;
    logic [CntW-1:0] slotCnt;
    logic [IdxW-1:0] rowIdx;
    lineVec          colMeta;
    lineVec          colSync;
    logic            slotEnd;
    logic            sampleNow;
    logic            sweepEnd;
    logic            slotHit;
    keyCode          slotCode;
    logic            candValid;
    keyCode          cand;
    logic            sweepValid;
    keyCode          sweepCode;
    logic            prevValid;
    keyCode          prevCode;
    logic            reported;

    // ----------------------------------------
    // Row timing
    // ----------------------------------------

    assign slotEnd   = (slotCnt == CntW'(ScanPeriod - 1));
    assign sampleNow = slotEnd && (state == scanRun);
    assign sweepEnd  = sampleNow && (rowIdx == IdxW'(KeyLines - 1));

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state   <= scanIdle;
            slotCnt <= '0;
            rowIdx  <= '0;
            row     <= lineVec'(1);
        end else begin
            // Synchronizer holds reset zeros for the first cycle
            if (state == scanIdle) begin
                state <= scanRun;
            end
            if (slotEnd) begin
                slotCnt <= '0;
                rowIdx  <= rowIdx + 1'b1;
                row     <= {row[KeyLines-2:0], row[KeyLines-1]};
            end else begin
                slotCnt <= slotCnt + 1'b1;
            end
        end
    end

    // Columns are asynchronous to clk
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            colMeta <= '0;
            colSync <= '0;
        end else begin
            colMeta <= col;
            colSync <= colMeta;
        end
    end

    // ----------------------------------------
    // Sweep candidate and debounce
    // ----------------------------------------

    assign slotHit    = |colSync;
    assign slotCode   = keyCode'(int'(rowIdx) * KeyLines + int'(lowestCol(colSync)));
    // Earlier rows hold lower codes, so an existing candidate stays
    assign sweepValid = candValid || slotHit;
    assign sweepCode  = candValid ? cand : slotCode;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            candValid <= 1'b0;
            prevValid <= 1'b0;
            reported  <= 1'b0;
            keyValid  <= 1'b0;
        end else begin
            keyValid <= 1'b0;
            if (sweepEnd) begin
                candValid <= 1'b0;
                prevValid <= sweepValid;
                if (!sweepValid) begin
                    // Empty sweep re-arms reporting
                    reported <= 1'b0;
                end else if (prevValid && (sweepCode == prevCode) && !reported) begin
                    keyValid <= 1'b1;
                    reported <= 1'b1;
                end
            end else if (sampleNow && slotHit) begin
                candValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleNow && slotHit && !candValid) begin
            cand <= slotCode;
        end
        if (sweepEnd) begin
            prevCode   <= sweepCode;
            keyCodeOut <= sweepCode;
        end
    end

endmodule

`default_nettype wire

// File: src/tonePkg.sv
`default_nettype none

package tonePkg;

    import keypadPkg::*;

    // ----------------------------------------
    // Pitch table
    // ----------------------------------------

    // Clock cycles in one half of the tone period
    typedef logic [15:0] halfPeriod;

    // Half-period of key code 0
    localparam int BaseHalf = 8;

    // Growth of the half-period per code step
    localparam int StepHalf = 2;

    // Higher code gives a longer period, so a lower pitch
    function automatic halfPeriod pitchHalf(input keyCode code);
        return halfPeriod'(BaseHalf + int'(code) * StepHalf);
    endfunction

    // ----------------------------------------
    // Player control
    // ----------------------------------------

    typedef enum logic {
        playIdle,
        playTone
    } playState;

endpackage

`default_nettype wire

// File: src/keypadPkg.sv
`default_nettype none

package keypadPkg;

    // ----------------------------------------
    // Keypad geometry
    // ----------------------------------------

    // Square matrix, rows and columns alike
    localparam int KeyLines = 4;

    // One bit per row or column line
    typedef logic [KeyLines-1:0] lineVec;

    // Row index times four plus column index
    typedef logic [3:0] keyCode;

    // ----------------------------------------
    // Scanner control
    // ----------------------------------------

    // Idle only right after reset, then scans for good
    typedef enum logic {
        scanIdle,
        scanRun
    } scanState;

endpackage

`default_nettype wire
